//--- verilog/uart_pkg.sv
package uart_pkg;

	// --------------------------------------------------
	// frame format
	// --------------------------------------------------
	localparam int data_bits = 8;
	// short bit period keeps simulation fast
	localparam int clks_per_bit = 8;
	localparam int parity_en = 1;
	localparam int even_parity = 1;
	localparam int stop_bits = 1;
	localparam int lsb_first = 1;
	// start + data + parity + stop
	localparam int frame_bits = 1 + data_bits + parity_en + stop_bits;

	// --------------------------------------------------
	// axi4-lite bus
	// --------------------------------------------------
	localparam int addr_width = 4;
	localparam int axil_data_width = 32;

	// register offsets
	localparam logic [addr_width-1:0] reg_txdata = 4'h0;
	localparam logic [addr_width-1:0] reg_rxdata = 4'h4;
	localparam logic [addr_width-1:0] reg_status = 4'h8;

	// response codes
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// status bit positions
	localparam int st_tx_busy = 0;
	localparam int st_rx_valid = 1;
	localparam int st_parity_err = 2;
	localparam int st_frame_err = 3;
	localparam int st_overrun = 4;

endpackage

//--- verilog/uart_word_if.sv
interface uart_word_if;
	import uart_pkg::*;

	// one serial word
	logic [data_bits-1:0] data;
	// transfer when both high
	logic valid;
	logic ready;
	// receive status, meaningful with valid
	logic parity_err;
	logic frame_err;

	// word producer
	modport source (
		output data, valid, parity_err, frame_err,
		input ready
	);

	// word consumer
	modport sink (
		input data, valid, parity_err, frame_err,
		output ready
	);

endinterface

//--- verilog/baud_tick_gen.sv
module baud_tick_gen (
	input  logic serial_clk,
	input  logic in_rst,
	input  logic clear,
	output logic baud_tick
);
	import uart_pkg::*;

	localparam int cnt_w = $clog2(clks_per_bit);

	// cycle position inside the current bit
	logic [cnt_w-1:0] cnt;

	// last cycle of a bit period
	// held off while cleared so the first bit starts in phase
	assign baud_tick = !clear && (cnt == cnt_w'(clks_per_bit - 1));

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			cnt <= '0;
		end else if (clear) begin
			// park at start of period
			cnt <= '0;
		end else if (baud_tick) begin
			// wrap for the next bit
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

//--- verilog/serial_async_tx.sv
module serial_async_tx (
	input  logic serial_clk,
	input  logic in_rst,
	input  logic baud_tick,
	output logic tick_clear,
	uart_word_if.sink word,
	output logic serial_tx
);
	import uart_pkg::*;

	localparam int ctr_w = $clog2(data_bits + 1);
	localparam int idx_w = $clog2(data_bits);
	// parity seed, odd sense starts at one
	localparam logic parity_init = (even_parity != 0) ? 1'b0 : 1'b1;

	typedef enum logic [2:0] {
		Ready,
		TransmitStart,
		TransmitData,
		TransmitParity,
		TransmitStop
	} tx_state_t;

	tx_state_t state, next_state;
	logic [ctr_w-1:0] bit_ctr, next_bit_ctr;
	logic [idx_w-1:0] bit_idx;
	logic [data_bits-1:0] tx_data;
	logic parity;
	logic line_level;
	logic take_word;

	// --------------------------------------------------
	// handshake and bit-rate control
	// --------------------------------------------------
	assign word.ready = (state == Ready);
	assign take_word = word.valid && word.ready;
	// bit clock restarts with each frame
	assign tick_clear = (state == Ready);

	// data bit order
	assign bit_idx = (lsb_first != 0) ? bit_ctr[idx_w-1:0] :
		idx_w'(data_bits - 1 - int'(bit_ctr));

	// --------------------------------------------------
	// next-state logic
	// --------------------------------------------------
	always_comb begin
		next_state = state;
		next_bit_ctr = bit_ctr;
		case (state)
			Ready: begin
				next_bit_ctr = '0;
				if (take_word)
					next_state = TransmitStart;
			end
			TransmitStart: begin
				if (baud_tick)
					next_state = TransmitData;
			end
			TransmitData: begin
				if (baud_tick) begin
					// last data bit?
					if (bit_ctr == ctr_w'(data_bits - 1)) begin
						next_bit_ctr = '0;
						next_state = (parity_en != 0) ? TransmitParity : TransmitStop;
					end else begin
						next_bit_ctr = bit_ctr + 1'b1;
					end
				end
			end
			TransmitParity: begin
				if (baud_tick)
					next_state = TransmitStop;
			end
			TransmitStop: begin
				if (baud_tick) begin
					if (bit_ctr == ctr_w'(stop_bits - 1)) begin
						next_bit_ctr = '0;
						next_state = Ready;
					end else begin
						next_bit_ctr = bit_ctr + 1'b1;
					end
				end
			end
			default: next_state = Ready;
		endcase
	end

	// line level per state
	always_comb begin
		case (state)
			TransmitStart: line_level = 1'b0;
			TransmitData: line_level = tx_data[bit_idx];
			TransmitParity: line_level = parity;
			default: line_level = 1'b1;
		endcase
	end

	// --------------------------------------------------
	// registers
	// --------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= Ready;
			bit_ctr <= '0;
			parity <= parity_init;
			// idle line is high
			serial_tx <= 1'b1;
		end else begin
			state <= next_state;
			bit_ctr <= next_bit_ctr;
			// glitch-free output
			serial_tx <= line_level;
			// running parity over sent data bits
			if (state == Ready || state == TransmitStart)
				parity <= parity_init;
			else if (state == TransmitData && baud_tick)
				parity <= parity ^ tx_data[bit_idx];
		end
	end

	// word captured at handshake
	always_ff @(posedge serial_clk) begin
		if (take_word)
			tx_data <= word.data;
	end

endmodule

//--- verilog/serial_async_rx.sv
module serial_async_rx (
	input  logic serial_clk,
	input  logic in_rst,
	input  logic serial_rx,
	uart_word_if.source word
);
	import uart_pkg::*;

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam int ctr_w = $clog2(data_bits + 1);
	localparam logic parity_init = (even_parity != 0) ? 1'b0 : 1'b1;

	typedef enum logic [2:0] {
		RxIdle,
		RxStart,
		RxData,
		RxParity,
		RxStop
	} rx_state_t;

	rx_state_t state;
	logic [1:0] sync_ff;
	logic line, line_prev, fall;
	logic [cnt_w-1:0] cnt;
	logic [ctr_w-1:0] bit_ctr;
	logic mid_bit;
	logic [data_bits-1:0] shift;
	logic parity;

	// --------------------------------------------------
	// line synchroniser and start edge
	// --------------------------------------------------
	assign line = sync_ff[1];
	assign fall = line_prev && !line;
	// one full period after the previous sample
	assign mid_bit = (cnt == cnt_w'(clks_per_bit - 1));
	assign word.data = shift;

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			sync_ff <= 2'b11;
			line_prev <= 1'b1;
		end else begin
			sync_ff <= {sync_ff[0], serial_rx};
			line_prev <= line;
		end
	end

	// --------------------------------------------------
	// frame decoder
	// --------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= RxIdle;
			cnt <= '0;
			bit_ctr <= '0;
			parity <= parity_init;
			word.valid <= 1'b0;
			word.parity_err <= 1'b0;
			word.frame_err <= 1'b0;
		end else begin
			// single-cycle pulse
			word.valid <= 1'b0;
			cnt <= cnt + 1'b1;
			case (state)
				RxIdle: begin
					cnt <= '0;
					if (fall)
						state <= RxStart;
				end
				RxStart: begin
					// half a bit in, line must still be low
					if (cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
						cnt <= '0;
						bit_ctr <= '0;
						parity <= parity_init;
						word.parity_err <= 1'b0;
						word.frame_err <= 1'b0;
						state <= line ? RxIdle : RxData;
					end
				end
				RxData: begin
					if (mid_bit) begin
						cnt <= '0;
						parity <= parity ^ line;
						if (bit_ctr == ctr_w'(data_bits - 1)) begin
							bit_ctr <= '0;
							state <= (parity_en != 0) ? RxParity : RxStop;
						end else begin
							bit_ctr <= bit_ctr + 1'b1;
						end
					end
				end
				RxParity: begin
					if (mid_bit) begin
						cnt <= '0;
						// accumulated parity plus parity bit gives zero when good
						word.parity_err <= parity ^ line;
						state <= RxStop;
					end
				end
				RxStop: begin
					if (mid_bit) begin
						cnt <= '0;
						// stop bit must be high
						if (!line)
							word.frame_err <= 1'b1;
						if (bit_ctr == ctr_w'(stop_bits - 1)) begin
							bit_ctr <= '0;
							word.valid <= 1'b1;
							state <= RxIdle;
						end else begin
							bit_ctr <= bit_ctr + 1'b1;
						end
					end
				end
				default: state <= RxIdle;
			endcase
		end
	end

	// data shift register
	always_ff @(posedge serial_clk) begin
		if (state == RxData && mid_bit) begin
			if (lsb_first != 0)
				shift <= {line, shift[data_bits-1:1]};
			else
				shift <= {shift[data_bits-2:0], line};
		end
	end

endmodule

//--- verilog/axil_uart_regs.sv
module axil_uart_regs (
	input  logic serial_clk,
	input  logic in_rst,
	input  logic [uart_pkg::addr_width-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [uart_pkg::axil_data_width-1:0] wdata,
	input  logic [uart_pkg::axil_data_width/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [uart_pkg::addr_width-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [uart_pkg::axil_data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	uart_word_if.source tx,
	uart_word_if.sink rx
);
	import uart_pkg::*;

	logic wr_accept, rd_accept;
	logic wr_txdata, wr_status, rd_rxdata;
	logic tx_busy, tx_load;
	logic [data_bits-1:0] rx_data;
	logic rx_valid_flag, par_err_flag, frm_err_flag, overrun_flag;
	logic [axil_data_width-1:0] status;

	// --------------------------------------------------
	// address handshakes
	// --------------------------------------------------
	// a pending response holds off its channel
	assign wr_accept = awvalid && wvalid && !bvalid;
	assign rd_accept = arvalid && !rvalid;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign arready = rd_accept;

	assign wr_txdata = wr_accept && (awaddr == reg_txdata) && wstrb[0];
	assign wr_status = wr_accept && (awaddr == reg_status) && wstrb[0];
	assign rd_rxdata = rd_accept && (araddr == reg_rxdata);

	// busy also covers a word not yet taken
	assign tx_busy = tx.valid || !tx.ready;
	assign tx_load = wr_txdata && !tx_busy;

	assign tx.parity_err = 1'b0;
	assign tx.frame_err = 1'b0;
	assign rx.ready = 1'b1;

	// write response
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			bvalid <= 1'b0;
			bresp <= resp_okay;
		end else begin
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_accept) begin
				bvalid <= 1'b1;
				if (awaddr == reg_txdata)
					bresp <= tx_busy ? resp_slverr : resp_okay;
				else if (awaddr == reg_status)
					bresp <= resp_okay;
				else
					bresp <= resp_slverr;
			end
		end
	end

	// --------------------------------------------------
	// transmit word and receive flags
	// --------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			tx.valid <= 1'b0;
		end else if (tx.valid && tx.ready) begin
			tx.valid <= 1'b0;
		end else if (tx_load) begin
			tx.valid <= 1'b1;
		end
	end

	always_ff @(posedge serial_clk) begin
		if (tx_load)
			tx.data <= wdata[data_bits-1:0];
		if (rx.valid && rx.ready)
			rx_data <= rx.data;
	end

	// sticky flags, new events win over clears
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			rx_valid_flag <= 1'b0;
			par_err_flag <= 1'b0;
			frm_err_flag <= 1'b0;
			overrun_flag <= 1'b0;
		end else begin
			if (wr_status) begin
				if (wdata[st_parity_err])
					par_err_flag <= 1'b0;
				if (wdata[st_frame_err])
					frm_err_flag <= 1'b0;
				if (wdata[st_overrun])
					overrun_flag <= 1'b0;
			end
			if (rd_rxdata)
				rx_valid_flag <= 1'b0;
			if (rx.valid && rx.ready) begin
				rx_valid_flag <= 1'b1;
				// unread word replaced
				if (rx_valid_flag)
					overrun_flag <= 1'b1;
				if (rx.parity_err)
					par_err_flag <= 1'b1;
				if (rx.frame_err)
					frm_err_flag <= 1'b1;
			end
		end
	end

	always_comb begin
		status = '0;
		status[st_tx_busy] = tx_busy;
		status[st_rx_valid] = rx_valid_flag;
		status[st_parity_err] = par_err_flag;
		status[st_frame_err] = frm_err_flag;
		status[st_overrun] = overrun_flag;
	end

	// --------------------------------------------------
	// read response
	// --------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			rvalid <= 1'b0;
			rresp <= resp_okay;
		end else begin
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_accept) begin
				rvalid <= 1'b1;
				if (araddr == reg_rxdata || araddr == reg_status)
					rresp <= resp_okay;
				else
					rresp <= resp_slverr;
			end
		end
	end

	always_ff @(posedge serial_clk) begin
		if (rd_accept) begin
			case (araddr)
				reg_rxdata: rdata <= axil_data_width'(rx_data);
				reg_status: rdata <= status;
				default: rdata <= '0;
			endcase
		end
	end

endmodule

//--- verilog/uart_axil_top.sv
module uart_axil_top (
	input  logic serial_clk,
	input  logic in_rst,
	// axi4-lite slave
	input  logic [uart_pkg::addr_width-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [uart_pkg::axil_data_width-1:0] wdata,
	input  logic [uart_pkg::axil_data_width/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [uart_pkg::addr_width-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [uart_pkg::axil_data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	// serial line
	output logic serial_tx,
	input  logic serial_rx
);

	logic baud_tick;
	logic tick_clear;

	// register block to transmitter, receiver to register block
	uart_word_if tx_word ();
	uart_word_if rx_word ();

	axil_uart_regs i_regs (
		.serial_clk (serial_clk), .in_rst (in_rst),
		.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
		.tx (tx_word.source), .rx (rx_word.sink)
	);

	baud_tick_gen i_baud (
		.serial_clk (serial_clk), .in_rst (in_rst),
		.clear (tick_clear), .baud_tick (baud_tick)
	);

	serial_async_tx i_tx (
		.serial_clk (serial_clk), .in_rst (in_rst), .baud_tick (baud_tick),
		.tick_clear (tick_clear), .word (tx_word.sink), .serial_tx (serial_tx)
	);

	serial_async_rx i_rx (
		.serial_clk (serial_clk), .in_rst (in_rst),
		.serial_rx (serial_rx), .word (rx_word.source)
	);

endmodule

//--- dv/uart_axil_checker.sv
module uart_axil_checker (
	input logic serial_clk,
	input logic in_rst,
	input logic serial_tx,
	input logic tx_busy,
	input logic bvalid,
	input logic bready,
	input logic [1:0] bresp,
	input logic rvalid,
	input logic rready,
	input logic [uart_pkg::axil_data_width-1:0] rdata
);

	// idle transmitter keeps the line high
	a_tx_idle_high: assert property (@(posedge serial_clk) disable iff (in_rst)
		!tx_busy |-> serial_tx)
		else $error("serial_tx low while transmitter idle");

	// responses wait for their ready
	a_bvalid_hold: assert property (@(posedge serial_clk) disable iff (in_rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");
	a_rvalid_hold: assert property (@(posedge serial_clk) disable iff (in_rst)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	// payload frozen while waiting
	a_bresp_stable: assert property (@(posedge serial_clk) disable iff (in_rst)
		bvalid && !bready |=> $stable(bresp))
		else $error("bresp changed while bvalid held");
	a_rdata_stable: assert property (@(posedge serial_clk) disable iff (in_rst)
		rvalid && !rready |=> $stable(rdata))
		else $error("rdata changed while rvalid held");

endmodule

//--- dv/uart_axil_tb.sv
module uart_axil_tb;
	import uart_pkg::*;

	logic serial_clk;
	logic in_rst;
	logic [addr_width-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [axil_data_width-1:0] wdata;
	logic [axil_data_width/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [addr_width-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [axil_data_width-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic serial_tx;
	logic serial_rx;

	// loopback unless the line driver is selected
	logic use_driver;
	logic drv_line;
	assign serial_rx = use_driver ? drv_line : serial_tx;

	int errors;
	int checks;
	logic loaded;
	// one entry per stimulus line
	byte ops[$];
	logic [7:0] b0_q[$];
	logic [7:0] b1_q[$];
	logic [7:0] exp_q[$];
	logic [7:0] flag_q[$];

	uart_axil_top i_dut (.*);

	bind uart_axil_top uart_axil_checker i_checker (
		.serial_clk (serial_clk), .in_rst (in_rst), .serial_tx (serial_tx),
		.tx_busy (i_regs.tx_busy), .bvalid (bvalid), .bready (bready), .bresp (bresp),
		.rvalid (rvalid), .rready (rready), .rdata (rdata)
	);

	always #2 serial_clk = ~serial_clk;

	// --------------------------------------------------
	// check and bus tasks
	// --------------------------------------------------
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int waited;
		int delay;
		int aw_seen;
		int w_seen;
		waited = 0;
		aw_seen = 0;
		w_seen = 0;
		resp = 2'b11;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		// bvalid up means the address was taken
		do begin
			// mid low phase, away from both edges
			#1;
			if (awready)
				aw_seen++;
			if (wready)
				w_seen++;
			@(negedge serial_clk);
			waited++;
		end while (!bvalid && waited < 20);
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!bvalid) begin
			errors++;
			$display("write to address 0x%h got no response", addr);
		end else begin
			// exactly one address and data handshake
			check("awready cycles", aw_seen, 1);
			check("wready cycles", w_seen, 1);
			resp = bresp;
			// random back-pressure
			delay = $urandom % 4;
			repeat (delay) @(negedge serial_clk);
			bready = 1'b1;
			@(negedge serial_clk);
			bready = 1'b0;
		end
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int waited;
		int delay;
		int ar_seen;
		waited = 0;
		ar_seen = 0;
		resp = 2'b11;
		data = 'x;
		araddr = addr;
		arvalid = 1'b1;
		do begin
			#1;
			if (arready)
				ar_seen++;
			@(negedge serial_clk);
			waited++;
		end while (!rvalid && waited < 20);
		arvalid = 1'b0;
		if (!rvalid) begin
			errors++;
			$display("read from address 0x%h got no response", addr);
		end else begin
			check("arready cycles", ar_seen, 1);
			resp = rresp;
			data = rdata;
			delay = $urandom % 4;
			repeat (delay) @(negedge serial_clk);
			rready = 1'b1;
			@(negedge serial_clk);
			rready = 1'b0;
		end
	endtask

	// read STATUS until the masked bits match
	task automatic poll_status(input logic [31:0] mask, input logic [31:0] value,
		output logic [31:0] st);
		int polls;
		logic [1:0] resp;
		polls = 0;
		do begin
			read_reg(reg_status, st, resp);
			polls++;
		end while ((st & mask) != value && polls < 200);
		if ((st & mask) != value) begin
			errors++;
			$display("status never reached 0x%h under mask 0x%h", value, mask);
		end
	endtask

	// start, data lsb first, even parity, stop, then idle
	task automatic send_frame(input logic [7:0] d, input logic bad_parity,
		input logic bad_stop);
		logic [frame_bits-1:0] bits;
		bits = {~bad_stop, (^d) ^ bad_parity, d, 1'b0};
		use_driver = 1'b1;
		for (int i = 0; i < frame_bits; i++) begin
			drv_line = bits[i];
			repeat (clks_per_bit) @(negedge serial_clk);
		end
		drv_line = 1'b1;
		repeat (clks_per_bit + 4) @(negedge serial_clk);
		use_driver = 1'b0;
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic load_stimulus();
		int fd;
		int n;
		string text;
		byte op;
		logic [7:0] a, b, c, d;
		fd = $fopen("dv/uart_stim.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open stimulus file dv/uart_stim.txt");
		end else begin
			while (!$feof(fd)) begin
				text = "";
				void'($fgets(text, fd));
				// skip comments and blank lines
				if (text.len() > 1 && text[0] != "#") begin
					n = $sscanf(text, "%c %h %h %h %h", op, a, b, c, d);
					if (n == 5) begin
						ops.push_back(op);
						b0_q.push_back(a);
						b1_q.push_back(b);
						exp_q.push_back(c);
						flag_q.push_back(d);
					end else begin
						errors++;
						$display("stimulus line not understood: %s", text);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_op(input byte op, input logic [7:0] b0, input logic [7:0] b1,
		input logic [7:0] exp_data, input logic [7:0] flags);
		logic [31:0] st;
		logic [31:0] rd;
		logic [1:0] resp;
		case (op)
			"L", "B": begin
				write_reg(reg_txdata, b0, resp);
				check("bresp", resp, resp_okay);
				if (op == "B") begin
					read_reg(reg_status, st, resp);
					check("status.tx_busy", st[st_tx_busy], 1);
					// second byte must be dropped
					write_reg(reg_txdata, b1, resp);
					check("bresp", resp, resp_slverr);
				end
				poll_status(1 << st_rx_valid, 1 << st_rx_valid, st);
				check("status", st & 32'h1e, flags);
				read_reg(reg_rxdata, rd, resp);
				check("rdata", rd, exp_data);
				check("rresp", resp, resp_okay);
				read_reg(reg_status, st, resp);
				check("status.rx_valid", st[st_rx_valid], 0);
				poll_status(1 << st_tx_busy, 0, st);
				if (op == "B") begin
					// nothing else may arrive
					repeat (2 * frame_bits * clks_per_bit) @(negedge serial_clk);
					read_reg(reg_status, st, resp);
					check("status", st, 0);
				end
			end
			"P": begin
				send_frame(b0, 1'b1, 1'b0);
				poll_status(1 << st_rx_valid, 1 << st_rx_valid, st);
				read_reg(reg_rxdata, rd, resp);
				check("rdata", rd, b0);
				send_frame(b1, 1'b0, 1'b1);
				poll_status(1 << st_rx_valid, 1 << st_rx_valid, st);
				check("status", st & 32'h1e, flags);
				read_reg(reg_rxdata, rd, resp);
				check("rdata", rd, exp_data);
				write_reg(reg_status, flags & 8'h1c, resp);
				check("bresp", resp, resp_okay);
				read_reg(reg_status, st, resp);
				check("status", st, 0);
			end
			"O": begin
				send_frame(b0, 1'b0, 1'b0);
				poll_status(1 << st_rx_valid, 1 << st_rx_valid, st);
				// second frame lands on an unread word
				send_frame(b1, 1'b0, 1'b0);
				read_reg(reg_status, st, resp);
				check("status", st & 32'h1e, flags);
				read_reg(reg_rxdata, rd, resp);
				check("rdata", rd, exp_data);
				write_reg(reg_status, 1 << st_overrun, resp);
				check("bresp", resp, resp_okay);
				read_reg(reg_status, st, resp);
				check("status", st, 0);
			end
			"A": begin
				write_reg(4'hc, b0, resp);
				check("bresp", resp, resp_slverr);
				write_reg(reg_rxdata, b0, resp);
				check("bresp", resp, resp_slverr);
				read_reg(4'hc, rd, resp);
				check("rdata", rd, exp_data);
				check("rresp", resp, resp_slverr);
				read_reg(reg_status, st, resp);
				check("status", st, flags);
			end
			default: begin
				errors++;
				$display("unknown opcode %c in stimulus", op);
			end
		endcase
	endtask

	// --------------------------------------------------
	// main sequence and watchdog
	// --------------------------------------------------
	initial begin
		logic [31:0] st;
		logic [1:0] resp;
		void'($urandom(32'h5ea));
		serial_clk = 1'b0;
		in_rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		use_driver = 1'b0;
		drv_line = 1'b1;
		errors = 0;
		checks = 0;
		loaded = 1'b0;
		load_stimulus();
		loaded = 1'b1;
		repeat (2) @(negedge serial_clk);
		in_rst = 1'b0;
		@(negedge serial_clk);
		// state right after reset
		check("serial_tx", serial_tx, 1);
		check("awready", awready, 0);
		check("wready", wready, 0);
		check("arready", arready, 0);
		check("bvalid", bvalid, 0);
		check("rvalid", rvalid, 0);
		read_reg(reg_status, st, resp);
		check("status", st, 0);
		check("rresp", resp, resp_okay);
		foreach (ops[i])
			run_op(ops[i], b0_q[i], b1_q[i], exp_q[i], flag_q[i]);
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		longint limit;
		wait (loaded == 1'b1);
		// three frames per stimulus line at 4 time units per cycle
		limit = longint'(ops.size()) * 3 * frame_bits * clks_per_bit * 4 + 4000;
		#(limit);
		$display("watchdog: run did not finish within %0d time units", limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- uart_axil_top.f
verilog/uart_pkg.sv
verilog/uart_word_if.sv
verilog/baud_tick_gen.sv
verilog/serial_async_tx.sv
verilog/serial_async_rx.sv
verilog/axil_uart_regs.sv
verilog/uart_axil_top.sv
dv/uart_axil_checker.sv
dv/uart_axil_tb.sv

//--- dv/uart_stim.txt
# op byte1 byte2 exp_data exp_flags (hex), flags are STATUS bits 4..1 once the last frame is in
# L loopback, B busy write, P bad parity then low stop, O overrun, A bad address
L a5 00 a5 02
L 3c 00 3c 02
L 00 00 00 02
L ff 00 ff 02
B 81 7e 81 02
B 55 aa 55 02
P c3 96 96 0e
P 01 fe fe 0e
O 12 34 34 12
O e7 18 18 12
A 5a 00 00 00
A 0f 00 00 00
L 69 00 69 02
L 80 00 80 02
